// ==== compile.f ====
+incdir+include
rtl/decode_pkg.sv
rtl/decode_control.sv
rtl/reg_file_bypass.sv
rtl/imm_extend.sv
rtl/branch_jump.sv
rtl/hazard_detect.sv
rtl/decode_stage.sv
verif/decode_tb.sv

// ==== rtl/branch_jump.sv ====
/*
   branch and jump resolve
   early condition test, target address and link value
*/
`timescale 1ns/1ps

module branch_jump #(
   parameter int data_w = 16
) (
   input  logic [data_w-1:0] rs_data,
   input  logic [data_w-1:0] pc,
   input  logic [data_w-1:0] immediate,
   input  decode_pkg::br_op_t br_op,
   output logic [data_w-1:0] branch_target,
   output logic [data_w-1:0] link_data,
   output logic              taken
);

   logic rs_zero;
   logic rs_neg;

   assign link_data = pc + data_w'(2);
   assign rs_zero   = (rs_data == '0);
   assign rs_neg    = rs_data[data_w-1];

   // register jumps are relative to rs, everything else to the next pc
   assign branch_target = (br_op == decode_pkg::br_jreg) ? rs_data + immediate
                                                         : link_data + immediate;

   always_comb begin
      case (br_op)
         decode_pkg::br_beqz:  taken = rs_zero;
         decode_pkg::br_bnez:  taken = !rs_zero;
         decode_pkg::br_bltz:  taken = rs_neg;
         decode_pkg::br_bgez:  taken = !rs_neg;
         decode_pkg::br_jdisp: taken = 1'b1;
         decode_pkg::br_jreg:  taken = 1'b1;
         default:              taken = 1'b0;
      endcase
   end

endmodule

// ==== rtl/decode_control.sv ====
/*
   decode control
   maps opcode and function field to the control set, bubble on stall
*/
`timescale 1ns/1ps

module decode_control (
   input  decode_pkg::opcode_t  opcode,
   input  decode_pkg::rfunc_t   func,
   input  logic                 stall,
   output decode_pkg::alu_op_t  alu_op,
   output logic                 alu_src,
   output logic                 mem_read,
   output logic                 mem_write,
   output logic                 mem_to_reg,
   output logic                 reg_write,
   output logic                 halt,
   output logic                 illegal,
   output logic                 uses_rs,
   output logic                 uses_rt,
   output decode_pkg::br_op_t   br_op,
   output decode_pkg::dst_sel_t dst_sel,
   output decode_pkg::ext_op_t  ext_op,
   output logic                 ext_sign
);

   always_comb begin
      // defaults describe a nop
      alu_op     = decode_pkg::alu_add;
      alu_src    = 1'b0;
      mem_read   = 1'b0;
      mem_write  = 1'b0;
      mem_to_reg = 1'b0;
      reg_write  = 1'b0;
      halt       = 1'b0;
      illegal    = 1'b0;
      uses_rs    = 1'b0;
      uses_rt    = 1'b0;
      br_op      = decode_pkg::br_none;
      dst_sel    = decode_pkg::dst_rd_r;
      ext_op     = decode_pkg::ext_imm5;
      ext_sign   = 1'b0;

      case (opcode)
         decode_pkg::op_halt: halt = 1'b1;
         decode_pkg::op_nop: ;
         decode_pkg::op_addi, decode_pkg::op_subi,
         decode_pkg::op_xori, decode_pkg::op_andni: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
            uses_rs   = 1'b1;
            dst_sel   = decode_pkg::dst_rd_i;
            // logic immediates are zero extended
            ext_sign  = (opcode == decode_pkg::op_addi) || (opcode == decode_pkg::op_subi);
            case (opcode)
               decode_pkg::op_subi: alu_op = decode_pkg::alu_sub;
               decode_pkg::op_xori: alu_op = decode_pkg::alu_xor;
               decode_pkg::op_andni: alu_op = decode_pkg::alu_andn;
               default: alu_op = decode_pkg::alu_add;
            endcase
         end
         decode_pkg::op_st: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
            uses_rs   = 1'b1;
            // store data comes from the rt field
            uses_rt   = 1'b1;
            ext_sign  = 1'b1;
         end
         decode_pkg::op_ld: begin
            alu_src    = 1'b1;
            mem_read   = 1'b1;
            mem_to_reg = 1'b1;
            reg_write  = 1'b1;
            uses_rs    = 1'b1;
            dst_sel    = decode_pkg::dst_rd_i;
            ext_sign   = 1'b1;
         end
         decode_pkg::op_beqz, decode_pkg::op_bnez,
         decode_pkg::op_bltz, decode_pkg::op_bgez: begin
            uses_rs  = 1'b1;
            ext_op   = decode_pkg::ext_imm8;
            ext_sign = 1'b1;
            case (opcode)
               decode_pkg::op_beqz: br_op = decode_pkg::br_beqz;
               decode_pkg::op_bnez: br_op = decode_pkg::br_bnez;
               decode_pkg::op_bltz: br_op = decode_pkg::br_bltz;
               default: br_op = decode_pkg::br_bgez;
            endcase
         end
         decode_pkg::op_lbi: begin
            alu_op    = decode_pkg::alu_pass_b;
            alu_src   = 1'b1;
            reg_write = 1'b1;
            dst_sel   = decode_pkg::dst_rs;
            ext_op    = decode_pkg::ext_imm8;
            ext_sign  = 1'b1;
         end
         decode_pkg::op_j, decode_pkg::op_jal: begin
            br_op     = decode_pkg::br_jdisp;
            ext_op    = decode_pkg::ext_disp11;
            ext_sign  = 1'b1;
            reg_write = (opcode == decode_pkg::op_jal);
            dst_sel   = decode_pkg::dst_link;
         end
         decode_pkg::op_jr, decode_pkg::op_jalr: begin
            br_op     = decode_pkg::br_jreg;
            uses_rs   = 1'b1;
            ext_op    = decode_pkg::ext_imm8;
            ext_sign  = 1'b1;
            reg_write = (opcode == decode_pkg::op_jalr);
            dst_sel   = decode_pkg::dst_link;
         end
         decode_pkg::op_rtype: begin
            reg_write = 1'b1;
            uses_rs   = 1'b1;
            uses_rt   = 1'b1;
            case (func)
               decode_pkg::fn_sub: alu_op = decode_pkg::alu_sub;
               decode_pkg::fn_xor: alu_op = decode_pkg::alu_xor;
               decode_pkg::fn_andn: alu_op = decode_pkg::alu_andn;
               default: alu_op = decode_pkg::alu_add;
            endcase
         end
         default: illegal = 1'b1;
      endcase

      // load-use stall turns this slot into a bubble
      if (stall) begin
         reg_write = 1'b0;
         mem_read  = 1'b0;
         mem_write = 1'b0;
         halt      = 1'b0;
         br_op     = decode_pkg::br_none;
      end
   end

   // an unknown opcode must never reach writeback
   always_comb begin
      assert (!(illegal && reg_write))
         else $error("illegal opcode %0h raised reg_write", opcode);
   end

endmodule

// ==== rtl/decode_pkg.sv ====
/*
   decode package
   instruction field encodings and control codes shared by the decode stage
*/
package decode_pkg;

   // major opcode, instruction bits 15..11
   typedef enum logic [4:0] {
      op_halt  = 5'b00000,
      op_nop   = 5'b00001,
      op_j     = 5'b00100,
      op_jr    = 5'b00101,
      op_jal   = 5'b00110,
      op_jalr  = 5'b00111,
      op_addi  = 5'b01000,
      op_subi  = 5'b01001,
      op_xori  = 5'b01010,
      op_andni = 5'b01011,
      op_beqz  = 5'b01100,
      op_bnez  = 5'b01101,
      op_bltz  = 5'b01110,
      op_bgez  = 5'b01111,
      op_st    = 5'b10000,
      op_ld    = 5'b10001,
      op_lbi   = 5'b11000,
      op_rtype = 5'b11011
   } opcode_t;

   // function field of the register format, bits 1..0
   typedef enum logic [1:0] {
      fn_add  = 2'b00,
      fn_sub  = 2'b01,
      fn_xor  = 2'b10,
      fn_andn = 2'b11
   } rfunc_t;

   typedef enum logic [3:0] {
      alu_add    = 4'd0,
      alu_sub    = 4'd1,
      alu_xor    = 4'd2,
      alu_andn   = 4'd3,
      alu_pass_b = 4'd4
   } alu_op_t;

   typedef enum logic [2:0] {
      br_none  = 3'd0,
      br_beqz  = 3'd1,
      br_bnez  = 3'd2,
      br_bltz  = 3'd3,
      br_bgez  = 3'd4,
      br_jdisp = 3'd5,
      br_jreg  = 3'd6
   } br_op_t;

   // which immediate field feeds the extender
   typedef enum logic [1:0] {
      ext_imm5   = 2'd0,
      ext_imm8   = 2'd1,
      ext_disp11 = 2'd2
   } ext_op_t;

   typedef enum logic [1:0] {
      dst_rd_r = 2'd0,
      dst_rd_i = 2'd1,
      dst_rs   = 2'd2,
      dst_link = 2'd3
   } dst_sel_t;

   // jal and jalr write the return address here
   localparam logic [2:0] link_reg = 3'd7;

endpackage

// ==== rtl/decode_stage.sv ====
/*
   decode stage
   splits the instruction, reads operands, extends the immediate,
   resolves branches early and detects load-use hazards
*/
`timescale 1ns/1ps

module decode_stage #(
   parameter int data_w = 16
) (
   input  logic                clk,
   input  logic                rst_n,
   input  logic [15:0]         inst,
   input  logic [data_w-1:0]   pc,
   input  logic                wb_write_en,
   input  logic [2:0]          wb_write_sel,
   input  logic [data_w-1:0]   wb_data,
   input  logic                id_ex_mem_read,
   input  logic [2:0]          id_ex_rd,
   output logic [data_w-1:0]   rs_data,
   output logic [data_w-1:0]   rt_data,
   output logic [data_w-1:0]   immediate,
   output logic [data_w-1:0]   branch_target,
   output logic [data_w-1:0]   link_data,
   output logic [2:0]          rs_sel,
   output logic [2:0]          rt_sel,
   output logic [2:0]          rd_sel,
   output decode_pkg::alu_op_t alu_op,
   output logic                alu_src,
   output logic                mem_read,
   output logic                mem_write,
   output logic                mem_to_reg,
   output logic                reg_write,
   output logic                halt,
   output logic                illegal,
   output logic                stall_decode,
   output logic                flush_fetch
);

   decode_pkg::br_op_t   br_op;
   decode_pkg::dst_sel_t dst_sel;
   decode_pkg::ext_op_t  ext_op;
   logic                 ext_sign;
   logic                 uses_rs;
   logic                 uses_rt;
   logic                 taken;

   assign rs_sel = inst[10:8];
   assign rt_sel = inst[7:5];

   // destination field depends on the instruction format
   always_comb begin
      case (dst_sel)
         decode_pkg::dst_rd_i: rd_sel = inst[7:5];
         decode_pkg::dst_rs:   rd_sel = inst[10:8];
         decode_pkg::dst_link: rd_sel = decode_pkg::link_reg;
         default:              rd_sel = inst[4:2];
      endcase
   end

   decode_control u_control (
      .opcode     (decode_pkg::opcode_t'(inst[15:11])),
      .func       (decode_pkg::rfunc_t'(inst[1:0])),
      .stall      (stall_decode),
      .alu_op     (alu_op),
      .alu_src    (alu_src),
      .mem_read   (mem_read),
      .mem_write  (mem_write),
      .mem_to_reg (mem_to_reg),
      .reg_write  (reg_write),
      .halt       (halt),
      .illegal    (illegal),
      .uses_rs    (uses_rs),
      .uses_rt    (uses_rt),
      .br_op      (br_op),
      .dst_sel    (dst_sel),
      .ext_op     (ext_op),
      .ext_sign   (ext_sign)
   );

   reg_file_bypass #(.data_w(data_w)) u_regs (
      .clk      (clk),
      .rst_n    (rst_n),
      .rd1_sel  (rs_sel),
      .rd2_sel  (rt_sel),
      .wr_en    (wb_write_en),
      .wr_sel   (wb_write_sel),
      .wr_data  (wb_data),
      .rd1_data (rs_data),
      .rd2_data (rt_data)
   );

   imm_extend #(.data_w(data_w)) u_ext (
      .inst      (inst),
      .ext_op    (ext_op),
      .ext_sign  (ext_sign),
      .immediate (immediate)
   );

   branch_jump #(.data_w(data_w)) u_bj (
      .rs_data       (rs_data),
      .pc            (pc),
      .immediate     (immediate),
      .br_op         (br_op),
      .branch_target (branch_target),
      .link_data     (link_data),
      .taken         (taken)
   );

   hazard_detect u_hazard (
      .rs_sel         (rs_sel),
      .rt_sel         (rt_sel),
      .id_ex_rd       (id_ex_rd),
      .uses_rs        (uses_rs),
      .uses_rt        (uses_rt),
      .id_ex_mem_read (id_ex_mem_read),
      .taken          (taken),
      .stall_decode   (stall_decode),
      .flush_fetch    (flush_fetch)
   );

endmodule

// ==== rtl/hazard_detect.sv ====
/*
   hazard detect
   load-use stall against the execute stage, fetch flush on a taken redirect
*/
`timescale 1ns/1ps

module hazard_detect (
   input  logic [2:0] rs_sel,
   input  logic [2:0] rt_sel,
   input  logic [2:0] id_ex_rd,
   input  logic       uses_rs,
   input  logic       uses_rt,
   input  logic       id_ex_mem_read,
   input  logic       taken,
   output logic       stall_decode,
   output logic       flush_fetch
);

   logic rs_hit;
   logic rt_hit;

   // only sources the instruction actually reads can conflict
   assign rs_hit = uses_rs && (rs_sel == id_ex_rd);
   assign rt_hit = uses_rt && (rt_sel == id_ex_rd);

   always_comb begin
      stall_decode = id_ex_mem_read && (rs_hit || rt_hit);
      // a stalled branch resolves again next cycle with the loaded value
      flush_fetch  = taken && !stall_decode;
   end

   always_comb begin
      assert (!(stall_decode && flush_fetch))
         else $error("stall and flush raised together");
   end

endmodule

// ==== rtl/imm_extend.sv ====
/*
   immediate extender
   picks the 5, 8 or 11 bit field and sign or zero extends it
*/
`timescale 1ns/1ps

module imm_extend #(
   parameter int data_w = 16
) (
   input  logic [15:0]         inst,
   input  decode_pkg::ext_op_t ext_op,
   input  logic                ext_sign,
   output logic [data_w-1:0]   immediate
);

   always_comb begin
      case (ext_op)
         decode_pkg::ext_imm8:
            immediate = {{(data_w-8){ext_sign & inst[7]}}, inst[7:0]};
         decode_pkg::ext_disp11:
            immediate = {{(data_w-11){ext_sign & inst[10]}}, inst[10:0]};
         default:
            immediate = {{(data_w-5){ext_sign & inst[4]}}, inst[4:0]};
      endcase
   end

endmodule

// ==== rtl/reg_file_bypass.sv ====
/*
   register file
   eight entries, synchronous write and clear, write data bypassed to reads
*/
`timescale 1ns/1ps

module reg_file_bypass #(
   parameter int data_w = 16
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic [2:0]        rd1_sel,
   input  logic [2:0]        rd2_sel,
   input  logic              wr_en,
   input  logic [2:0]        wr_sel,
   input  logic [data_w-1:0] wr_data,
   output logic [data_w-1:0] rd1_data,
   output logic [data_w-1:0] rd2_data
);

   logic [data_w-1:0] regs [8];

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_sel] <= wr_data;
      end
   end

   // same-cycle writeback wins over the stored value
   always_comb begin
      if (wr_en && (wr_sel == rd1_sel)) begin
         rd1_data = wr_data;
      end else begin
         rd1_data = regs[rd1_sel];
      end
      if (wr_en && (wr_sel == rd2_sel)) begin
         rd2_data = wr_data;
      end else begin
         rd2_data = regs[rd2_sel];
      end
   end

   a_wr_sel_known: assert property (
      @(posedge clk) disable iff (!rst_n) wr_en |-> !$isunknown(wr_sel)
   ) else $error("writeback index unknown while write enabled");

endmodule

// ==== run.sh ====
#!/bin/sh
# build the decode stage testbench with Verilator, run it and grade the log
rm -f sim.log
verilator --binary --timing --assert --top-module decode_tb -f compile.f -o decode_tb_sim \
   && ./obj_dir/decode_tb_sim > sim.log 2>&1 \
   || echo "build or simulation did not complete" >> sim.log
cat sim.log
grep -q "Done: no errors" sim.log && echo "simulation passed" || {
   echo "simulation failed"
   exit 1
}

// ==== include/decode_tb_model.svh ====
/*
   decode reference model
   expected control, immediate and branch results plus a shadow register file
*/
`ifndef DECODE_TB_MODEL_SVH
`define DECODE_TB_MODEL_SVH

logic [15:0] shadow_regs [8];

// expected decode of the current instruction
// m_flags holds alu_src, mem_read, mem_write, mem_to_reg, reg_write, halt, illegal
// m_kind is 0 for none, 1 to 4 for beqz bnez bltz bgez, 5 jump by displacement, 6 by register
logic [3:0]  m_alu_op;
logic [6:0]  m_flags;
logic [1:0]  m_uses;
logic [2:0]  m_rd_sel;
logic [15:0] m_imm;
logic [2:0]  m_kind;

task automatic model_decode(input logic [15:0] ins);
   logic [4:0] op;
   int         width;
   logic       sx;
   op       = ins[15:11];
   m_alu_op = 4'd0;
   m_flags  = 7'b0000000;
   m_uses   = 2'b00;
   m_rd_sel = ins[4:2];
   m_kind   = 3'd0;
   width    = 5;
   sx       = 1'b0;
   case (op)
      decode_pkg::op_halt: m_flags = 7'b0000010;
      decode_pkg::op_nop: m_flags = 7'b0000000;
      decode_pkg::op_addi, decode_pkg::op_subi,
      decode_pkg::op_xori, decode_pkg::op_andni: begin
         m_alu_op = {2'b00, op[1:0]};
         m_flags  = 7'b1000100;
         m_uses   = 2'b10;
         m_rd_sel = ins[7:5];
         // add and subtract take a signed immediate
         sx       = !op[1];
      end
      decode_pkg::op_st: begin
         m_flags = 7'b1010000;
         m_uses  = 2'b11;
         sx      = 1'b1;
      end
      decode_pkg::op_ld: begin
         m_flags  = 7'b1101100;
         m_uses   = 2'b10;
         m_rd_sel = ins[7:5];
         sx       = 1'b1;
      end
      decode_pkg::op_beqz, decode_pkg::op_bnez,
      decode_pkg::op_bltz, decode_pkg::op_bgez: begin
         m_uses = 2'b10;
         m_kind = 3'd1 + 3'(op[1:0]);
         width  = 8;
         sx     = 1'b1;
      end
      decode_pkg::op_lbi: begin
         m_alu_op = 4'd4;
         m_flags  = 7'b1000100;
         m_rd_sel = ins[10:8];
         width    = 8;
         sx       = 1'b1;
      end
      decode_pkg::op_j, decode_pkg::op_jr,
      decode_pkg::op_jal, decode_pkg::op_jalr: begin
         // opcode bit 1 marks the linking forms, bit 0 the register forms
         m_flags  = op[1] ? 7'b0000100 : 7'b0000000;
         m_uses   = op[0] ? 2'b10 : 2'b00;
         m_kind   = op[0] ? 3'd6 : 3'd5;
         m_rd_sel = 3'd7;
         width    = op[0] ? 8 : 11;
         sx       = 1'b1;
      end
      decode_pkg::op_rtype: begin
         m_alu_op = {2'b00, ins[1:0]};
         m_flags  = 7'b0000100;
         m_uses   = 2'b11;
      end
      default: m_flags = 7'b0000001;
   endcase
   case (width)
      8:       m_imm = {{8{sx & ins[7]}}, ins[7:0]};
      11:      m_imm = {{5{sx & ins[10]}}, ins[10:0]};
      default: m_imm = {{11{sx & ins[4]}}, ins[4:0]};
   endcase
endtask

task automatic model_branch(input logic [15:0] rs, input logic [15:0] pc_val,
                            output logic taken, output logic [15:0] target);
   case (m_kind)
      3'd1:       taken = (rs == 16'h0000);
      3'd2:       taken = (rs != 16'h0000);
      3'd3:       taken = rs[15];
      3'd4:       taken = !rs[15];
      3'd5, 3'd6: taken = 1'b1;
      default:    taken = 1'b0;
   endcase
   target = (m_kind == 3'd6) ? rs + m_imm : pc_val + 16'd2 + m_imm;
endtask

`endif

// ==== verif/decode_tb.sv ====
/*
   decode stage testbench
   random instructions, writebacks and load hazards checked against a model
*/
`timescale 1ns/1ps

module decode_tb;

   localparam int data_w = 16;

   localparam logic [4:0] op_list [18] = '{
      decode_pkg::op_halt, decode_pkg::op_nop, decode_pkg::op_addi, decode_pkg::op_subi,
      decode_pkg::op_xori, decode_pkg::op_andni, decode_pkg::op_st, decode_pkg::op_ld,
      decode_pkg::op_beqz, decode_pkg::op_bnez, decode_pkg::op_bltz, decode_pkg::op_bgez,
      decode_pkg::op_lbi, decode_pkg::op_j, decode_pkg::op_jr, decode_pkg::op_jal,
      decode_pkg::op_jalr, decode_pkg::op_rtype
   };
   localparam logic [4:0] br_list [8] = '{
      decode_pkg::op_beqz, decode_pkg::op_bnez, decode_pkg::op_bltz, decode_pkg::op_bgez,
      decode_pkg::op_j, decode_pkg::op_jr, decode_pkg::op_jal, decode_pkg::op_jalr
   };

   logic                clk;
   logic                rst_n;
   logic [15:0]         inst;
   logic [data_w-1:0]   pc;
   logic                wb_write_en;
   logic [2:0]          wb_write_sel;
   logic [data_w-1:0]   wb_data;
   logic                id_ex_mem_read;
   logic [2:0]          id_ex_rd;
   logic [data_w-1:0]   rs_data;
   logic [data_w-1:0]   rt_data;
   logic [data_w-1:0]   immediate;
   logic [data_w-1:0]   branch_target;
   logic [data_w-1:0]   link_data;
   logic [2:0]          rs_sel;
   logic [2:0]          rt_sel;
   logic [2:0]          rd_sel;
   decode_pkg::alu_op_t alu_op;
   logic                alu_src;
   logic                mem_read;
   logic                mem_write;
   logic                mem_to_reg;
   logic                reg_write;
   logic                halt;
   logic                illegal;
   logic                stall_decode;
   logic                flush_fetch;

   int errors;
   int checks;
   int err_mark;

   `include "decode_tb_model.svh"

   decode_stage #(.data_w(data_w)) DUT (
      .clk            (clk),
      .rst_n          (rst_n),
      .inst           (inst),
      .pc             (pc),
      .wb_write_en    (wb_write_en),
      .wb_write_sel   (wb_write_sel),
      .wb_data        (wb_data),
      .id_ex_mem_read (id_ex_mem_read),
      .id_ex_rd       (id_ex_rd),
      .rs_data        (rs_data),
      .rt_data        (rt_data),
      .immediate      (immediate),
      .branch_target  (branch_target),
      .link_data      (link_data),
      .rs_sel         (rs_sel),
      .rt_sel         (rt_sel),
      .rd_sel         (rd_sel),
      .alu_op         (alu_op),
      .alu_src        (alu_src),
      .mem_read       (mem_read),
      .mem_write      (mem_write),
      .mem_to_reg     (mem_to_reg),
      .reg_write      (reg_write),
      .halt           (halt),
      .illegal        (illegal),
      .stall_decode   (stall_decode),
      .flush_fetch    (flush_fetch)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   task automatic check_value(input string name, input logic [15:0] expected,
                              input logic [15:0] actual);
      checks++;
      if (actual !== expected) begin
         $display("error %s expected %h got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_outputs();
      logic [15:0] exp_rs;
      logic [15:0] exp_rt;
      logic [15:0] exp_target;
      logic [6:0]  flags;
      logic        exp_stall;
      logic        exp_taken;
      model_decode(inst);
      exp_rs = shadow_regs[inst[10:8]];
      exp_rt = shadow_regs[inst[7:5]];
      // a writeback in this cycle is already visible to both reads
      if (wb_write_en && (wb_write_sel == inst[10:8])) begin
         exp_rs = wb_data;
      end
      if (wb_write_en && (wb_write_sel == inst[7:5])) begin
         exp_rt = wb_data;
      end
      exp_stall = id_ex_mem_read && ((m_uses[1] && (inst[10:8] == id_ex_rd)) ||
                                     (m_uses[0] && (inst[7:5] == id_ex_rd)));
      flags = m_flags;
      if (exp_stall) begin
         // bubble drops mem_read, mem_write, reg_write, halt and the redirect
         flags  = flags & 7'b1001001;
         m_kind = 3'd0;
      end
      model_branch(exp_rs, pc, exp_taken, exp_target);
      check_value("rs_data", exp_rs, rs_data);
      check_value("rt_data", exp_rt, rt_data);
      check_value("rs_sel", 16'(inst[10:8]), 16'(rs_sel));
      check_value("rt_sel", 16'(inst[7:5]), 16'(rt_sel));
      check_value("rd_sel", 16'(m_rd_sel), 16'(rd_sel));
      check_value("alu_op", 16'(m_alu_op), 16'(alu_op));
      check_value("alu_src", 16'(flags[6]), 16'(alu_src));
      check_value("mem_read", 16'(flags[5]), 16'(mem_read));
      check_value("mem_write", 16'(flags[4]), 16'(mem_write));
      check_value("mem_to_reg", 16'(flags[3]), 16'(mem_to_reg));
      check_value("reg_write", 16'(flags[2]), 16'(reg_write));
      check_value("halt", 16'(flags[1]), 16'(halt));
      check_value("illegal", 16'(flags[0]), 16'(illegal));
      check_value("immediate", m_imm, immediate);
      check_value("link_data", pc + 16'd2, link_data);
      check_value("branch_target", exp_target, branch_target);
      check_value("stall_decode", 16'(exp_stall), 16'(stall_decode));
      check_value("flush_fetch", 16'(exp_taken && !exp_stall), 16'(flush_fetch));
   endtask

   // inputs are set one ns after an edge, checked one ns before the next
   task automatic apply_and_check();
      #2;
      check_outputs();
      @(posedge clk);
      if (wb_write_en) begin
         shadow_regs[wb_write_sel] = wb_data;
      end
      #1;
   endtask

   task automatic drive_idle();
      inst           = {decode_pkg::op_nop, 11'd0};
      pc             = '0;
      wb_write_en    = 1'b0;
      wb_write_sel   = 3'd0;
      wb_data        = '0;
      id_ex_mem_read = 1'b0;
      id_ex_rd       = 3'd0;
   endtask

   task automatic finish_test(input string name);
      $display("test %s finished, %0d errors", name, errors - err_mark);
      err_mark = errors;
   endtask

   initial begin
      errors   = 0;
      checks   = 0;
      err_mark = 0;
      void'($urandom(32'hb35c_7beb));
      rst_n = 1'b0;
      drive_idle();
      // writebacks during reset must lose to the clear
      wb_write_en = 1'b1;
      for (int i = 0; i < 4; i++) begin
         wb_write_sel = 3'(2 * i + 1);
         wb_data      = 16'($urandom) | 16'h0001;
         @(posedge clk);
         #1;
      end
      drive_idle();
      for (int i = 0; i < 8; i++) begin
         shadow_regs[i] = '0;
      end
      rst_n = 1'b1;

      // all zero inputs first, then random register pairs
      inst = '0;
      apply_and_check();
      for (int i = 0; i < 16; i++) begin
         inst = {decode_pkg::op_rtype, 11'($urandom)};
         apply_and_check();
      end
      finish_test("reset");

      for (int i = 0; i < 40; i++) begin
         inst         = {decode_pkg::op_rtype, 11'($urandom)};
         wb_write_en  = 1'($urandom);
         wb_write_sel = (i % 3 == 0) ? inst[10:8] :
                        (i % 3 == 1) ? inst[7:5] : 3'($urandom);
         wb_data      = 16'($urandom);
         apply_and_check();
      end
      drive_idle();
      finish_test("register write and bypass");

      for (int i = 0; i < 80; i++) begin
         inst = 16'($urandom);
         apply_and_check();
      end
      finish_test("control decode");

      for (int i = 0; i < 54; i++) begin
         inst = {op_list[5'($urandom % 18)], 11'($urandom)};
         apply_and_check();
      end
      finish_test("immediate extension");

      for (int i = 0; i < 48; i++) begin
         inst         = {br_list[3'($urandom)], 11'($urandom)};
         pc           = 16'($urandom);
         wb_write_en  = 1'($urandom);
         wb_write_sel = (i % 3 != 2) ? inst[10:8] : 3'($urandom);
         // zero values make the equality branches go both ways
         wb_data      = (i % 2 == 0) ? 16'h0000 : 16'($urandom);
         apply_and_check();
      end
      drive_idle();
      finish_test("branch and jump");

      for (int i = 0; i < 48; i++) begin
         inst           = {op_list[5'($urandom % 18)], 11'($urandom)};
         pc             = 16'($urandom);
         id_ex_mem_read = (i % 4 != 3);
         id_ex_rd       = (i % 3 == 0) ? inst[10:8] :
                          (i % 3 == 1) ? inst[7:5] : 3'($urandom);
         apply_and_check();
      end
      drive_idle();
      apply_and_check();
      finish_test("load-use hazard");

      $display("tests 6, checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule
